// File: logic/invaders_pkg.sv
package invaders_pkg;

	//////////////////////////////////////////////////
	// coordinates and colours
	//////////////////////////////////////////////////

	localparam int COORD_W = 10;

	// one screen coordinate, plus one spare bit for sums
	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [COORD_W:0] coord_ext_t;

	// colour byte is blue | green | red
	typedef logic [7:0] color_t;

	// visible area
	localparam coord_t SCREEN_W = 10'd640;
	localparam coord_t SCREEN_H = 10'd480;

	localparam color_t COLOR_ALIEN = 8'b10101010;
	localparam color_t COLOR_SPACE = 8'b00000000;
	localparam color_t COLOR_RED = 8'b00000111;
	localparam color_t COLOR_BLUE = 8'b11000000;
	localparam color_t COLOR_GREEN = 8'b00111000;
	// flat start screen
	localparam color_t COLOR_YELLOW = 8'b00111111;

	// border rows
	localparam coord_t SCOREBOARD_TOP = 10'd0;
	localparam coord_t SCOREBOARD_BOTTOM = 10'd40;
	localparam coord_t BARRIER_TOP = 10'd340;
	localparam coord_t BARRIER_BOTTOM = 10'd400;
	localparam coord_t EXTRA_LIVES_TOP = 10'd460;

	//////////////////////////////////////////////////
	// alien formation
	//////////////////////////////////////////////////

	localparam coord_t ALIEN_COUNT = 10'd11;
	localparam coord_t ALIEN_PITCH = 10'd50;
	localparam coord_t ALIEN_W = 10'd30;
	localparam coord_t ALIEN_H = 10'd20;
	localparam coord_t START_X = 10'd70;
	localparam coord_t START_Y = 10'd90;
	localparam coord_t STEP_X = 10'd10;
	localparam coord_t STEP_Y = 10'd10;

	// whole row width incl. the gap after the last alien
	localparam coord_t ROW_SPAN = 10'd550;
	// origin to right edge of the last alien
	localparam coord_t RIGHT_REACH = 10'd530;

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_t;

	typedef enum logic [1:0] {MODE_BLANK, MODE_START, MODE_GAME} screen_mode_t;

	typedef enum logic [1:0] {MARCH_RIGHT, MARCH_LEFT, LANDED} march_state_t;

	// top-left corner of alien 0
	typedef struct packed {
		coord_t x;
		coord_t y;
	} formation_t;

endpackage

// File: logic/pixel_intake.sv
module pixel_intake (
	input  logic clk,
	input  logic rst,
	input  logic button_display,
	input  logic in_valid,
	output logic in_ready,
	input  invaders_pkg::pixel_t in_pix,
	output logic stage_valid,
	input  logic stage_ready,
	output invaders_pkg::pixel_t stage_pix,
	output invaders_pkg::screen_mode_t stage_mode,
	output logic frame_start,
	output logic reform
);

	logic button_prev;
	logic button_rise;
	logic take;
	logic drain;
	invaders_pkg::screen_mode_t mode;

	//////////////////////////////////////////////////
	// button edge and screen mode
	//////////////////////////////////////////////////

	assign button_rise = button_display & ~button_prev;

	// edge seen now, pulse out next cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			button_prev <= 1'b0;
			reform <= 1'b0;
		end else begin
			button_prev <= button_display;
			reform <= button_rise;
		end
	end

	// blank -> start -> game -> blank
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mode <= invaders_pkg::MODE_BLANK;
		end else if (reform) begin
			case (mode)
				invaders_pkg::MODE_BLANK: mode <= invaders_pkg::MODE_START;
				invaders_pkg::MODE_START: mode <= invaders_pkg::MODE_GAME;
				default: mode <= invaders_pkg::MODE_BLANK;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// one-entry skid register
	//////////////////////////////////////////////////

	// open when empty or emptying this cycle
	assign in_ready = ~stage_valid | stage_ready;
	assign take = in_valid & in_ready;
	assign drain = stage_valid & stage_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage_valid <= 1'b0;
		end else if (take) begin
			stage_valid <= 1'b1;
		end else if (drain) begin
			stage_valid <= 1'b0;
		end
	end

	// mode travels with its pixel
	always_ff @(posedge clk) begin
		if (take) begin
			stage_pix <= in_pix;
			stage_mode <= mode;
		end
	end

	// frame start fires as (0,0) moves on to compose,
	// so that pixel still sees the old origin even when stalled
	assign frame_start = drain && (stage_pix == '0) && (stage_mode == invaders_pkg::MODE_GAME);

	// held pixel must not change while compose is full
	assert property (@(posedge clk) disable iff (rst)
		stage_valid && !stage_ready |=> stage_valid && $stable(stage_pix) && $stable(stage_mode));

endmodule

// File: logic/formation_ctrl.sv
module formation_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic frame_start,
	input  logic reform,
	output invaders_pkg::formation_t formation
);

	invaders_pkg::march_state_t state;
	invaders_pkg::march_state_t state_nxt;
	invaders_pkg::formation_t origin;
	invaders_pkg::formation_t origin_nxt;
	invaders_pkg::coord_ext_t reach_next;
	invaders_pkg::coord_ext_t drop_bottom;
	logic at_right;
	logic at_left;
	logic step_down;

	//////////////////////////////////////////////////
	// edge tests
	//////////////////////////////////////////////////

	// right edge of last alien after one more step right
	assign reach_next = invaders_pkg::coord_ext_t'(origin.x)
		+ invaders_pkg::coord_ext_t'(invaders_pkg::RIGHT_REACH)
		+ invaders_pkg::coord_ext_t'(invaders_pkg::STEP_X);
	assign at_right = reach_next > invaders_pkg::coord_ext_t'(invaders_pkg::SCREEN_W);

	// no room for another step left
	assign at_left = origin.x < invaders_pkg::STEP_X;

	// row bottom after a step down
	assign drop_bottom = invaders_pkg::coord_ext_t'(origin.y)
		+ invaders_pkg::coord_ext_t'(invaders_pkg::STEP_Y)
		+ invaders_pkg::coord_ext_t'(invaders_pkg::ALIEN_H);

	//////////////////////////////////////////////////
	// march FSM
	//////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		origin_nxt = origin;
		step_down = 1'b0;
		if (reform) begin
			// re-form at the start corner
			state_nxt = invaders_pkg::MARCH_RIGHT;
			origin_nxt.x = invaders_pkg::START_X;
			origin_nxt.y = invaders_pkg::START_Y;
		end else if (frame_start) begin
			case (state)
				invaders_pkg::MARCH_RIGHT: begin
					if (at_right) begin
						step_down = 1'b1;
						state_nxt = invaders_pkg::MARCH_LEFT;
					end else begin
						origin_nxt.x = origin.x + invaders_pkg::STEP_X;
					end
				end
				invaders_pkg::MARCH_LEFT: begin
					if (at_left) begin
						step_down = 1'b1;
						state_nxt = invaders_pkg::MARCH_RIGHT;
					end else begin
						origin_nxt.x = origin.x - invaders_pkg::STEP_X;
					end
				end
				// landed, nothing moves until re-form
				default: begin
					state_nxt = invaders_pkg::LANDED;
				end
			endcase
			if (step_down) begin
				origin_nxt.y = origin.y + invaders_pkg::STEP_Y;
				// bottom touches the barrier line
				if (drop_bottom >= invaders_pkg::coord_ext_t'(invaders_pkg::BARRIER_TOP)) begin
					state_nxt = invaders_pkg::LANDED;
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= invaders_pkg::MARCH_RIGHT;
			origin.x <= invaders_pkg::START_X;
			origin.y <= invaders_pkg::START_Y;
		end else begin
			state <= state_nxt;
			origin <= origin_nxt;
		end
	end

	assign formation = origin;

	// last alien stays inside the visible area
	assert property (@(posedge clk) disable iff (rst)
		invaders_pkg::coord_ext_t'(formation.x)
		+ invaders_pkg::coord_ext_t'(invaders_pkg::RIGHT_REACH)
		<= invaders_pkg::coord_ext_t'(invaders_pkg::SCREEN_W));

endmodule

// File: logic/sprite_match.sv
module sprite_match (
	input  invaders_pkg::pixel_t pix,
	input  invaders_pkg::formation_t formation,
	output logic is_alien
);

	invaders_pkg::coord_t dx;
	invaders_pkg::coord_t col_idx;
	invaders_pkg::coord_t col_x;
	invaders_pkg::coord_ext_t row_end;
	logic right_of_origin;
	logic in_row_span;
	logic in_body;
	logic in_band;

	//////////////////////////////////////////////////
	// horizontal test
	//////////////////////////////////////////////////

	// offset only counts when the pixel is at or past the origin
	assign right_of_origin = pix.x >= formation.x;
	assign dx = pix.x - formation.x;
	assign in_row_span = right_of_origin && (dx < invaders_pkg::ROW_SPAN);

	// which alien slot and where inside it
	assign col_idx = dx / invaders_pkg::ALIEN_PITCH;
	assign col_x = dx - col_idx * invaders_pkg::ALIEN_PITCH;

	// gap between aliens is the tail of each pitch
	assign in_body = col_x < invaders_pkg::ALIEN_W;

	//////////////////////////////////////////////////
	// vertical test
	//////////////////////////////////////////////////

	// wide sum so origin y near the bottom cannot wrap
	assign row_end = invaders_pkg::coord_ext_t'(formation.y)
		+ invaders_pkg::coord_ext_t'(invaders_pkg::ALIEN_H);

	assign in_band = (pix.y >= formation.y)
		&& (invaders_pkg::coord_ext_t'(pix.y) < row_end);

	// every alien alive and all share one shape
	assign is_alien = in_row_span && in_body && in_band;

endmodule

// File: logic/pixel_compose.sv
module pixel_compose (
	input  logic clk,
	input  logic rst,
	input  logic stage_valid,
	output logic stage_ready,
	input  invaders_pkg::pixel_t stage_pix,
	input  invaders_pkg::screen_mode_t stage_mode,
	input  logic is_alien,
	output logic out_valid,
	input  logic out_ready,
	output invaders_pkg::color_t out_rgb
);

	invaders_pkg::color_t color;
	logic on_screen;
	logic score_row;
	logic barrier_row;
	logic lives_row;
	logic load;

	//////////////////////////////////////////////////
	// row and area decode
	//////////////////////////////////////////////////

	assign on_screen = (stage_pix.x < invaders_pkg::SCREEN_W)
		&& (stage_pix.y < invaders_pkg::SCREEN_H);

	assign score_row = (stage_pix.y == invaders_pkg::SCOREBOARD_TOP)
		|| (stage_pix.y == invaders_pkg::SCOREBOARD_BOTTOM);
	assign barrier_row = (stage_pix.y == invaders_pkg::BARRIER_TOP)
		|| (stage_pix.y == invaders_pkg::BARRIER_BOTTOM);
	assign lives_row = stage_pix.y == invaders_pkg::EXTRA_LIVES_TOP;

	//////////////////////////////////////////////////
	// priority paint
	//////////////////////////////////////////////////

	always_comb begin
		color = invaders_pkg::COLOR_SPACE;
		if (on_screen) begin
			case (stage_mode)
				invaders_pkg::MODE_START: color = invaders_pkg::COLOR_YELLOW;
				invaders_pkg::MODE_GAME: begin
					// borders first, then aliens, then space
					if (score_row) begin
						color = invaders_pkg::COLOR_RED;
					end else if (barrier_row) begin
						color = invaders_pkg::COLOR_BLUE;
					end else if (lives_row) begin
						color = invaders_pkg::COLOR_GREEN;
					end else if (is_alien) begin
						color = invaders_pkg::COLOR_ALIEN;
					end
				end
				// blank screen stays space
				default: color = invaders_pkg::COLOR_SPACE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	// take a new colour when empty or being read
	assign stage_ready = ~out_valid | out_ready;
	assign load = stage_valid & stage_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			out_rgb <= color;
		end
	end

	// stalled output holds its colour
	assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_rgb));

endmodule

// File: logic/invaders_top.sv
module invaders_top (
	input  logic clk,
	input  logic rst,
	input  logic button_display,
	input  logic in_valid,
	output logic in_ready,
	input  invaders_pkg::pixel_t in_pix,
	output logic out_valid,
	input  logic out_ready,
	output invaders_pkg::color_t out_rgb
);

	// intake to compose
	logic stage_valid;
	logic stage_ready;
	invaders_pkg::pixel_t stage_pix;
	invaders_pkg::screen_mode_t stage_mode;

	// formation control
	logic frame_start;
	logic reform;
	invaders_pkg::formation_t formation;
	logic is_alien;

	//////////////////////////////////////////////////
	// input side
	//////////////////////////////////////////////////

	pixel_intake u_intake (
		.clk(clk),
		.rst(rst),
		.button_display(button_display),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_pix(in_pix),
		.stage_valid(stage_valid),
		.stage_ready(stage_ready),
		.stage_pix(stage_pix),
		.stage_mode(stage_mode),
		.frame_start(frame_start),
		.reform(reform)
	);

	//////////////////////////////////////////////////
	// aliens
	//////////////////////////////////////////////////

	formation_ctrl u_formation (
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.reform(reform),
		.formation(formation)
	);

	// hit test on the pixel waiting in the intake register
	sprite_match u_match (
		.pix(stage_pix),
		.formation(formation),
		.is_alien(is_alien)
	);

	//////////////////////////////////////////////////
	// output side
	//////////////////////////////////////////////////

	pixel_compose u_compose (
		.clk(clk),
		.rst(rst),
		.stage_valid(stage_valid),
		.stage_ready(stage_ready),
		.stage_pix(stage_pix),
		.stage_mode(stage_mode),
		.is_alien(is_alien),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_rgb(out_rgb)
	);

endmodule

// File: testbench/tb_checker.sv
module tb_checker (
	input  logic clk,
	input  logic rst,
	input  logic out_valid,
	input  logic out_ready,
	input  invaders_pkg::color_t out_rgb
);

	// expected colours in input order, each with its test id
	invaders_pkg::color_t exp_q[$];
	int id_q[$];

	invaders_pkg::color_t exp_rgb;
	int exp_id;
	int cur_id = 0;
	int cur_count = 0;
	int cur_errs = 0;
	int checked = 0;
	int errors = 0;

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic push_expected(input invaders_pkg::color_t rgb, input int id);
		exp_q.push_back(rgb);
		id_q.push_back(id);
	endtask

	// summary for the test that just ended
	task automatic close_test();
		if (cur_count != 0) begin
			if (cur_errs == 0) begin
				$display("test %0d passed, %0d pixels", cur_id, cur_count);
			end else begin
				$display("test %0d failed, %0d of %0d pixels wrong", cur_id, cur_errs, cur_count);
			end
		end
		cur_count = 0;
		cur_errs = 0;
	endtask

	//////////////////////////////////////////////////
	// output stream compare
	//////////////////////////////////////////////////

	// valid and ready settle well before the rising edge
	always @(negedge clk) begin
		if (!rst && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("extra colour on the output with no pixel left to expect");
				errors++;
			end else begin
				exp_rgb = exp_q.pop_front();
				exp_id = id_q.pop_front();
				// first pixel of the next test
				if (exp_id != cur_id) begin
					close_test();
					cur_id = exp_id;
				end
				cur_count++;
				checked++;
				if (out_rgb !== exp_rgb) begin
					$display("Fail out_rgb test %0d: expected %h, got %h", exp_id, exp_rgb, out_rgb);
					cur_errs++;
					errors++;
				end
			end
		end
	end

endmodule

// File: testbench/tb_invaders.sv
module tb_invaders;

	localparam logic [31:0] SEED = 32'h48da6b49;

	// table actions
	localparam int PIX = 0;
	localparam int BTN = 1;
	localparam int RND = 2;

	// action, pixel (or burst length in x), test id
	typedef struct packed {
		int act;
		int x;
		int y;
		int id;
	} entry_t;

	entry_t stim [41] = '{
		// blank screen, then start screen
		'{PIX, 320, 240, 1}, '{PIX, 0, 0, 1}, '{PIX, 700, 10, 1}, '{BTN, 0, 0, 1},
		'{PIX, 5, 5, 1}, '{PIX, 639, 479, 1}, '{PIX, 640, 0, 1},
		// game screen, borders and aliens at the start corner
		'{BTN, 0, 0, 2}, '{PIX, 300, 0, 2}, '{PIX, 300, 40, 2}, '{PIX, 300, 340, 2},
		'{PIX, 300, 400, 2}, '{PIX, 300, 460, 2}, '{PIX, 70, 90, 2}, '{PIX, 570, 109, 2},
		'{PIX, 100, 90, 2}, '{PIX, 70, 110, 2}, '{PIX, 700, 200, 2},
		// march right, drop at the edge, march left
		'{PIX, 0, 0, 3}, '{PIX, 0, 0, 3}, '{PIX, 0, 0, 3}, '{PIX, 0, 0, 3},
		'{PIX, 110, 90, 3}, '{PIX, 109, 90, 3}, '{PIX, 0, 0, 3}, '{PIX, 110, 100, 3},
		'{PIX, 110, 99, 3}, '{PIX, 0, 0, 3}, '{PIX, 100, 119, 3}, '{PIX, 130, 100, 3},
		// back to blank, then re-form in game mode
		'{BTN, 0, 0, 4}, '{PIX, 110, 100, 4}, '{BTN, 0, 0, 4}, '{BTN, 0, 0, 4},
		'{PIX, 70, 90, 4}, '{PIX, 69, 90, 4}, '{PIX, 99, 109, 4},
		// random bursts under back-pressure
		'{PIX, 0, 0, 5}, '{RND, 80, 0, 5}, '{PIX, 0, 0, 5}, '{RND, 80, 0, 5}
	};

	logic clk;
	logic rst;
	logic button_display;
	logic in_valid;
	logic in_ready;
	invaders_pkg::pixel_t in_pix;
	logic out_valid;
	logic out_ready;
	invaders_pkg::color_t out_rgb;

	// reference model of mode and formation
	invaders_pkg::screen_mode_t ref_mode;
	invaders_pkg::march_state_t ref_state;
	int ox;
	int oy;

	logic [31:0] ready_rng;
	logic [31:0] pix_rng;

	invaders_top DUT (.*);

	tb_checker u_check (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic invaders_pkg::color_t ref_color(input int x, input int y);
		int dx;
		dx = x - ox;
		if (x >= 640 || y >= 480 || ref_mode == invaders_pkg::MODE_BLANK) begin
			return invaders_pkg::COLOR_SPACE;
		end else if (ref_mode == invaders_pkg::MODE_START) begin
			return invaders_pkg::COLOR_YELLOW;
		end else if (y == 0 || y == 40) begin
			return invaders_pkg::COLOR_RED;
		end else if (y == 340 || y == 400) begin
			return invaders_pkg::COLOR_BLUE;
		end else if (y == 460) begin
			return invaders_pkg::COLOR_GREEN;
		end else if (y >= oy && y < oy + 20 && dx >= 0 && dx < 550 && dx % 50 < 30) begin
			return invaders_pkg::COLOR_ALIEN;
		end
		return invaders_pkg::COLOR_SPACE;
	endfunction

	// one formation step per game frame
	task automatic march_step();
		if (ref_state == invaders_pkg::MARCH_RIGHT && ox + 540 > 640) begin
			oy += 10;
			ref_state = invaders_pkg::MARCH_LEFT;
		end else if (ref_state == invaders_pkg::MARCH_RIGHT) begin
			ox += 10;
		end else if (ref_state == invaders_pkg::MARCH_LEFT && ox < 10) begin
			oy += 10;
			ref_state = invaders_pkg::MARCH_RIGHT;
		end else if (ref_state == invaders_pkg::MARCH_LEFT) begin
			ox -= 10;
		end
		// row bottom on the barrier line
		if (oy + 20 >= 340) begin
			ref_state = invaders_pkg::LANDED;
		end
	endtask

	//////////////////////////////////////////////////
	// drivers
	//////////////////////////////////////////////////

	task automatic send_pixel(input int x, input int y, input int id);
		logic taken;
		taken = 1'b0;
		// (0,0) still gets the old origin
		u_check.push_expected(ref_color(x, y), id);
		if (x == 0 && y == 0 && ref_mode == invaders_pkg::MODE_GAME) begin
			march_step();
		end
		in_pix.x = invaders_pkg::coord_t'(x);
		in_pix.y = invaders_pkg::coord_t'(y);
		in_valid = 1'b1;
		while (!taken) begin
			@(negedge clk);
			taken = in_ready;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic press_button();
		// drain first so no pixel in flight sees the new mode
		while (u_check.pending() != 0) begin
			@(posedge clk);
			#1;
		end
		button_display = 1'b1;
		@(posedge clk);
		#1;
		button_display = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		case (ref_mode)
			invaders_pkg::MODE_BLANK: ref_mode = invaders_pkg::MODE_START;
			invaders_pkg::MODE_START: ref_mode = invaders_pkg::MODE_GAME;
			default: ref_mode = invaders_pkg::MODE_BLANK;
		endcase
		// every press re-forms the row
		ref_state = invaders_pkg::MARCH_RIGHT;
		ox = 70;
		oy = 90;
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// random back-pressure, roughly one stall in four
	initial begin
		out_ready = 1'b0;
		ready_rng = SEED;
		forever begin
			@(posedge clk);
			#1;
			ready_rng = lcg_next(ready_rng);
			out_ready = ready_rng[31:30] != 2'b00;
		end
	end

	initial begin
		rst = 1'b1;
		button_display = 1'b0;
		in_valid = 1'b0;
		in_pix = '0;
		pix_rng = lcg_next(SEED);
		ref_mode = invaders_pkg::MODE_BLANK;
		ref_state = invaders_pkg::MARCH_RIGHT;
		ox = 70;
		oy = 90;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		foreach (stim[i]) begin
			case (stim[i].act)
				BTN: press_button();
				RND: begin
					// x anywhere, y around the alien row
					repeat (stim[i].x) begin
						pix_rng = lcg_next(pix_rng);
						send_pixel(int'(pix_rng[9:0]), 80 + int'(pix_rng[25:20]), stim[i].id);
					end
				end
				default: send_pixel(stim[i].x, stim[i].y, stim[i].id);
			endcase
		end
		while (u_check.pending() != 0) begin
			@(posedge clk);
			#1;
		end
		u_check.close_test();
		$display("%0d pixels checked, %0d errors", u_check.checked, u_check.errors);
		if (u_check.errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// 20 cycles per pixel in the table, plus reset
	initial begin : watchdog
		int limit;
		limit = 40;
		foreach (stim[j]) begin
			limit += (stim[j].act == RND) ? stim[j].x * 20 : 20;
		end
		repeat (limit) @(posedge clk);
		$display("timeout: the pixel stream made no progress within %0d cycles", limit);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: invaders.f
logic/invaders_pkg.sv
logic/pixel_intake.sv
logic/formation_ctrl.sv
logic/sprite_match.sv
logic/pixel_compose.sv
logic/invaders_top.sv
testbench/tb_checker.sv
testbench/tb_invaders.sv

// File: Makefile
TOP = tb_invaders

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f invaders.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
